// File: Bender.yml
package:
  name: wr_reducer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/wr_pkg.sv
      - src/wr_fifo.sv
      - src/wr_cfg.sv
      - src/wr_reducer.sv
      - src/wr_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/wr_clkgen.sv
      - sim/wr_sva.sv
      - sim/wr_tb.sv

// File: include/wr_params.svh
`ifndef WR_PARAMS_SVH
`define WR_PARAMS_SVH

// width of the words written by the producer.
`define WR_DIN_WIDTH 128

// width of each slice on the output stream.
`define WR_DOUT_WIDTH 64

// slices per wide word, the input width must be a multiple of the output width.
`define WR_SLICES (`WR_DIN_WIDTH / `WR_DOUT_WIDTH)

// number of wide beats buffered in front of the reducer.
`define WR_FIFO_DEPTH 8

// config register map.
`define WR_ADDR_CTRL 1'b0
`define WR_ADDR_COUNT 1'b1

// data width of the config port.
`define WR_CFG_WIDTH 32

`endif

// File: sim/wr_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module wr_clkgen #(
  parameter int PERIOD_NS = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic RD_CLK,
  output logic RD_RESETN
);

  initial begin
    RD_CLK = 1'b0;
    forever begin
      #(PERIOD_NS / 2) RD_CLK = ~RD_CLK;
    end
  end

  // reset is released on a rising edge so the synchronous flops see clean cycles.
  initial begin
    RD_RESETN = 1'b0;
    repeat (RESET_CYCLES) @(posedge RD_CLK);
    RD_RESETN <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/wr_sva.sv
`timescale 1ns/1ps
`default_nettype none

module wr_sva (
  input wire                      RD_CLK,
  input wire                      RD_RESETN,
  input wire wr_pkg::wr_out_s     out,
  input wire                      out_ready,
  input wire wr_pkg::wr_cfg_req_s cfg,
  input wire wr_pkg::wr_cfg_rsp_s cfg_rsp,
  input wire                      pop,
  input wire                      not_empty
);

  int unsigned sva_errors = 0;  // read by the testbench to stop the run.

  a_out_hold: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    (out.valid && !out_ready) |=> (out.valid && $stable(out)))
  else begin
    sva_errors++;
    $error("out changed while it was stalled by out_ready.");
  end

  a_ack_rise: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    $rose(cfg_rsp.ack) |-> cfg.req)
  else begin
    sva_errors++;
    $error("ack rose while req was low.");
  end

  a_empty_pop: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    $fell(not_empty) |-> $past(pop))
  else begin
    sva_errors++;
    $error("the FIFO went empty without a pop.");
  end

endmodule

bind wr_top wr_sva i_sva (
  .RD_CLK    (RD_CLK),
  .RD_RESETN (RD_RESETN),
  .out       (out),
  .out_ready (out_ready),
  .cfg       (cfg),
  .cfg_rsp   (cfg_rsp),
  .pop       (pop),
  .not_empty (not_empty)
);

`default_nettype wire

// File: sim/wr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wr_params.svh"

module wr_tb;

  import wr_pkg::*;

  localparam int SLICES = `WR_SLICES;
  localparam int FILL = `WR_FIFO_DEPTH;
  localparam int N_LOW = 16;
  localparam int N_HIGH = 16;
  localparam int N_RANDOM = 40;
  localparam int TOTAL_WORDS = FILL + N_LOW + N_HIGH + N_RANDOM;
  localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 200;

  logic RD_CLK;
  logic RD_RESETN;
  wr_in_s in_s;
  logic in_ready;
  wr_out_s out_s;
  logic out_ready;
  wr_cfg_req_s cfg;
  wr_cfg_rsp_s cfg_rsp;

  logic [31:0] lcg_state = 32'd67785;
  logic [`WR_DIN_WIDTH-1:0] word_q[$];  // accepted input words not yet started on the output.
  logic [`WR_DIN_WIDTH-1:0] cur_word;
  int slice_k = 0;
  int words_out = 0;
  int cycles = 0;
  bit msb_mode = 1'b0;

  wr_clkgen i_clkgen (
    .RD_CLK    (RD_CLK),
    .RD_RESETN (RD_RESETN)
  );

  wr_top i_dut (
    .RD_CLK    (RD_CLK),
    .RD_RESETN (RD_RESETN),
    .in        (in_s),
    .in_ready  (in_ready),
    .out       (out_s),
    .out_ready (out_ready),
    .cfg       (cfg),
    .cfg_rsp   (cfg_rsp)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // slice 0 is the low end of the word, msb order walks from the top.
  function automatic logic [`WR_DOUT_WIDTH-1:0] expected_slice(
    input logic [`WR_DIN_WIDTH-1:0] word, input bit msb, input int k);
    int pos;
    pos = msb ? (SLICES - 1 - k) : k;
    return word[pos*`WR_DOUT_WIDTH +: `WR_DOUT_WIDTH];
  endfunction

  task automatic stop_with_failure(input string why);
    if (why != "") begin
      $display("%s", why);
    end
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic compare_values(input string name, input logic [`WR_DIN_WIDTH-1:0] got,
                                input logic [`WR_DIN_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      stop_with_failure("");
    end
  endtask

  task automatic present_next_word(input bit rand_valid);
    wr_in_s nxt;
    logic [31:0] r;
    r = next_random();
    nxt.valid = rand_valid ? r[16] : 1'b1;
    nxt.data.word = {next_random(), next_random(), next_random(), next_random()};
    in_s <= nxt;
  endtask

  task automatic send_words(input int n, input bit rand_valid, input bit rand_ready);
    int sent;
    bit accepted;
    logic [31:0] r;
    sent = 0;
    @(posedge RD_CLK);
    present_next_word(rand_valid);
    while (sent < n) begin
      @(posedge RD_CLK);
      accepted = in_s.valid && in_ready;
      if (accepted) begin
        sent++;
      end
      r = next_random();
      out_ready <= rand_ready ? r[24] : 1'b1;
      if (sent == n) begin
        in_s.valid <= 1'b0;
      end else if (accepted || !in_s.valid) begin
        present_next_word(rand_valid);  // a word that is not taken stays on the bus.
      end
    end
  endtask

  task automatic wait_drained();
    out_ready <= 1'b1;
    do begin
      @(posedge RD_CLK);
    end while (word_q.size() != 0 || slice_k != 0 || out_s.valid);
  endtask

  task automatic cfg_access(input bit we, input bit addr, input logic [`WR_CFG_WIDTH-1:0] wdata,
                            output logic [`WR_CFG_WIDTH-1:0] rdata);
    wr_cfg_req_s req;
    req.req = 1'b1;
    req.we = we;
    req.addr = addr;
    req.wdata = wdata;
    @(posedge RD_CLK);
    cfg <= req;
    do begin
      @(posedge RD_CLK);
    end while (!cfg_rsp.ack);
    rdata = cfg_rsp.rdata;
    req.req = 1'b0;
    cfg <= req;
    do begin
      @(posedge RD_CLK);
    end while (cfg_rsp.ack);
  endtask

  // scoreboard for the input and output streams.
  always @(posedge RD_CLK) begin
    if (RD_RESETN) begin
      if (in_s.valid && in_ready) begin
        word_q.push_back(in_s.data.word);
      end
      if (out_s.valid && out_ready) begin
        if (slice_k == 0 && word_q.size() == 0) begin
          stop_with_failure("An output slice appeared with no input word waiting for it.");
        end else begin
          if (slice_k == 0) begin
            cur_word = word_q.pop_front();
          end
          compare_values("out.data", out_s.data, expected_slice(cur_word, msb_mode, slice_k));
          compare_values("out.last", out_s.last, slice_k == SLICES - 1);
          if (slice_k == SLICES - 1) begin
            slice_k = 0;
            words_out++;
          end else begin
            slice_k++;
          end
        end
      end
      if (i_dut.i_sva.sva_errors != 0) begin
        stop_with_failure("A bound assertion on the DUT failed.");
      end
    end
  end

  always @(posedge RD_CLK) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      stop_with_failure($sformatf("Timeout, the run did not end within %0d cycles.",
                                  CYCLE_LIMIT));
    end
  end

  initial begin
    logic [`WR_CFG_WIDTH-1:0] rd;
    int accepts;
    in_s = '0;
    out_ready = 1'b1;
    cfg = '0;
    do begin
      @(posedge RD_CLK);
    end while (!RD_RESETN);

    compare_values("out.valid", out_s.valid, 1'b0);
    cfg_access(1'b0, `WR_ADDR_CTRL, '0, rd);
    compare_values("ctrl", rd, 0);
    accepts = 0;
    present_next_word(1'b0);
    do begin
      @(posedge RD_CLK);
      compare_values("out.valid", out_s.valid, 1'b0);  // still disabled.
      if (in_s.valid && in_ready) begin
        accepts++;
        present_next_word(1'b0);
      end
    end while (in_ready);
    in_s.valid <= 1'b0;
    compare_values("accepted words", accepts, FILL);

    cfg_access(1'b1, `WR_ADDR_CTRL, 32'h1, rd);
    send_words(N_LOW, 1'b0, 1'b0);
    wait_drained();

    msb_mode = 1'b1;
    cfg_access(1'b1, `WR_ADDR_CTRL, 32'h3, rd);
    cfg_access(1'b0, `WR_ADDR_CTRL, '0, rd);
    compare_values("ctrl", rd, 3);
    send_words(N_HIGH, 1'b0, 1'b0);
    wait_drained();

    msb_mode = 1'b0;
    cfg_access(1'b1, `WR_ADDR_CTRL, 32'h1, rd);
    send_words(N_RANDOM, 1'b1, 1'b1);
    wait_drained();

    cfg_access(1'b0, `WR_ADDR_COUNT, '0, rd);
    compare_values("count", rd, TOTAL_WORDS);
    compare_values("words_out", words_out, TOTAL_WORDS);
    cfg_access(1'b1, `WR_ADDR_COUNT, 32'h1234_5678, rd);
    cfg_access(1'b0, `WR_ADDR_COUNT, '0, rd);
    compare_values("count", rd, TOTAL_WORDS);  // the write must not stick.

    @(negedge RD_CLK);
    if (i_dut.i_sva.sva_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/wr_cfg.sv
`timescale 1ns/1ps
`default_nettype none

`include "wr_params.svh"

module wr_cfg (
  input  wire                      RD_CLK,
  input  wire                      RD_RESETN,
  input  wire wr_pkg::wr_cfg_req_s cfg,
  output wr_pkg::wr_cfg_rsp_s      cfg_rsp,
  output wr_pkg::wr_ctrl_s         ctrl,
  input  wire                      word_done
);

  logic ack_q;
  logic [`WR_CFG_WIDTH-1:0] rdata_q;
  logic [`WR_CFG_WIDTH-1:0] count_q;
  logic access;

  // the access happens once, on the first cycle of req.
  assign access = cfg.req & ~ack_q;

  assign cfg_rsp.ack = ack_q;
  assign cfg_rsp.rdata = rdata_q;

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      ack_q <= 1'b0;
    end else if (access) begin
      ack_q <= 1'b1;
    end else if (!cfg.req) begin
      ack_q <= 1'b0;  // req dropped, close the handshake.
    end
  end

  // a written value is live in the cycle that ack rises.
  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      ctrl.enable <= 1'b0;
      ctrl.msb_first <= 1'b0;
    end else if (access && cfg.we && cfg.addr == `WR_ADDR_CTRL) begin
      ctrl.enable <= cfg.wdata[0];
      ctrl.msb_first <= cfg.wdata[1];
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      count_q <= '0;
    end else if (word_done) begin
      count_q <= count_q + 1'b1;
    end
  end

  // count is read only, so writes to its address only complete the handshake.
  always_ff @(posedge RD_CLK) begin
    if (access && !cfg.we) begin
      if (cfg.addr == `WR_ADDR_COUNT) begin
        rdata_q <= count_q;
      end else begin
        rdata_q <= `WR_CFG_WIDTH'(ctrl);
      end
    end
  end

endmodule

`default_nettype wire

// File: src/wr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "wr_params.svh"

module wr_fifo (
  input  wire                 RD_CLK,
  input  wire                 RD_RESETN,
  input  wire wr_pkg::wr_in_s in,
  output logic                in_ready,
  input  wire                 pop,
  output logic                not_empty,
  output wr_pkg::wr_beat_u    rd_data
);

  import wr_pkg::*;

  localparam int DEPTH = `WR_FIFO_DEPTH;
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
  localparam logic [AW:0] COUNT_FULL = (AW + 1)'(DEPTH);

  wr_beat_u mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0] count;
  logic push;
  logic take;

  // pointers wrap explicitly so the depth need not be a power of two.
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == PTR_LAST) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready = (count != COUNT_FULL);
  assign not_empty = (count != '0);
  assign push = in.valid & in_ready;
  assign take = pop & not_empty;  // a pop on an empty FIFO is dropped.

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= next_ptr(wr_ptr);
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      rd_ptr <= '0;
    end else if (take) begin
      rd_ptr <= next_ptr(rd_ptr);
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      count <= '0;
    end else begin
      case ({push, take})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;  // idle, or push and pop together.
        end
      endcase
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (push) begin
      mem[wr_ptr] <= in.data;
    end
  end

  // rd_data keeps the last popped beat until the next pop.
  always_ff @(posedge RD_CLK) begin
    if (take) begin
      rd_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: src/wr_pkg.sv
`default_nettype none

`include "wr_params.svh"

package wr_pkg;

  typedef logic [`WR_DOUT_WIDTH-1:0] wr_slice_t;

  // one FIFO entry, written whole and read back slice by slice.
  typedef union packed {
    logic [`WR_DIN_WIDTH-1:0] word;
    wr_slice_t [`WR_SLICES-1:0] slice;  // slice 0 sits in the low bits.
  } wr_beat_u;

  typedef struct packed {
    logic valid;
    wr_beat_u data;
  } wr_in_s;

  typedef struct packed {
    logic valid;
    logic last;  // set on the final slice of a word.
    wr_slice_t data;
  } wr_out_s;

  typedef struct packed {
    logic req;
    logic we;
    logic addr;
    logic [`WR_CFG_WIDTH-1:0] wdata;
  } wr_cfg_req_s;

  typedef struct packed {
    logic ack;
    logic [`WR_CFG_WIDTH-1:0] rdata;
  } wr_cfg_rsp_s;

  // bit 0 is enable and bit 1 is msb_first in the control register.
  typedef struct packed {
    logic msb_first;
    logic enable;
  } wr_ctrl_s;

endpackage

`default_nettype wire

// File: src/wr_reducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "wr_params.svh"

module wr_reducer (
  input  wire                   RD_CLK,
  input  wire                   RD_RESETN,
  input  wire wr_pkg::wr_ctrl_s ctrl,
  input  wire                   not_empty,
  output logic                  pop,
  input  wire wr_pkg::wr_beat_u rd_data,
  output wr_pkg::wr_out_s       out,
  input  wire                   out_ready,
  output logic                  word_done
);

  import wr_pkg::*;

  localparam int SLICES = `WR_SLICES;
  localparam int IW = (SLICES > 1) ? $clog2(SLICES) : 1;
  localparam logic [IW-1:0] IDX_TOP = IW'(SLICES - 1);

  // word being presented on the output.
  wr_beat_u beat_q;
  logic held_q;
  logic down_q;
  logic [IW-1:0] idx_q;

  // rd_data holds a popped beat that has not been taken yet.
  logic slot_q;

  logic last;
  logic accept;
  logic last_acc;
  logic load;

  assign last = down_q ? (idx_q == '0) : (idx_q == IDX_TOP);
  assign accept = held_q & out_ready;
  assign last_acc = accept & last;

  // the waiting beat moves in when nothing is held or the last slice leaves.
  assign load = slot_q & (~held_q | last_acc);

  // refill the slot as soon as it is free or being emptied this cycle.
  assign pop = ctrl.enable & not_empty & (~slot_q | load);

  assign word_done = last_acc;

  assign out.valid = held_q;
  assign out.last = last;
  assign out.data = beat_q.slice[idx_q];

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      slot_q <= 1'b0;
    end else if (pop) begin
      slot_q <= 1'b1;  // the FIFO registers the beat at this edge.
    end else if (load) begin
      slot_q <= 1'b0;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      held_q <= 1'b0;
    end else if (load) begin
      held_q <= 1'b1;
    end else if (last_acc) begin
      held_q <= 1'b0;
    end
  end

  // the order is latched per word so a change never splits a word.
  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      down_q <= 1'b0;
      idx_q <= '0;
    end else if (load) begin
      down_q <= ctrl.msb_first;
      idx_q <= ctrl.msb_first ? IDX_TOP : '0;
    end else if (accept && !last) begin
      if (down_q) begin
        idx_q <= idx_q - 1'b1;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (load) begin
      beat_q <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: src/wr_top.sv
`timescale 1ns/1ps
`default_nettype none

module wr_top (
  input  wire                      RD_CLK,
  input  wire                      RD_RESETN,
  input  wire wr_pkg::wr_in_s      in,
  output logic                     in_ready,
  output wr_pkg::wr_out_s          out,
  input  wire                      out_ready,
  input  wire wr_pkg::wr_cfg_req_s cfg,
  output wr_pkg::wr_cfg_rsp_s      cfg_rsp
);

  import wr_pkg::*;

  logic pop;
  logic not_empty;
  wr_beat_u rd_data;
  wr_ctrl_s ctrl;
  logic word_done;

  wr_fifo i_fifo (
    .RD_CLK    (RD_CLK),
    .RD_RESETN (RD_RESETN),
    .in        (in),
    .in_ready  (in_ready),
    .pop       (pop),
    .not_empty (not_empty),
    .rd_data   (rd_data)
  );

  wr_cfg i_cfg (
    .RD_CLK    (RD_CLK),
    .RD_RESETN (RD_RESETN),
    .cfg       (cfg),
    .cfg_rsp   (cfg_rsp),
    .ctrl      (ctrl),
    .word_done (word_done)
  );

  wr_reducer i_reducer (
    .RD_CLK    (RD_CLK),
    .RD_RESETN (RD_RESETN),
    .ctrl      (ctrl),
    .not_empty (not_empty),
    .pop       (pop),
    .rd_data   (rd_data),
    .out       (out),
    .out_ready (out_ready),
    .word_done (word_done)
  );

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
src/wr_pkg.sv
src/wr_fifo.sv
src/wr_cfg.sv
src/wr_reducer.sv
src/wr_top.sv
sim/wr_clkgen.sv
sim/wr_sva.sv
sim/wr_tb.sv
